/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - hw/decode_pkg.sv
      - hw/reg_file.sv
      - hw/control_unit.sv
      - hw/jump_unit.sv
      - hw/decode_stage.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/decode_properties.sv
      - verif/decode_tb.sv

/* all.f */
hw/decode_pkg.sv
hw/reg_file.sv
hw/control_unit.sv
hw/jump_unit.sv
hw/decode_stage.sv
verif/tb_clock.sv
verif/decode_properties.sv
verif/decode_tb.sv

/* hw/control_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module control_unit (
  input  wire logic                clk,
  input  wire logic                rst,
  input  wire logic                enable,
  input  wire decode_pkg::opcode_t opcode,
  input  wire logic                interrupt,
  input  wire logic                load_use,
  input  wire logic                taken,
  output decode_pkg::ctrl_t        ctrl
);

  decode_pkg::seq_state_e state;
  decode_pkg::seq_state_e state_next;
  logic rti_q;  // pop sequence came from RTI
  logic rti_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= decode_pkg::IDLE;
      rti_q <= 1'b0;
    end else if (enable && !load_use) begin
      state <= state_next;
      rti_q <= rti_next;
    end
  end

  always_comb begin
    ctrl = '0;
    ctrl.alu_op = decode_pkg::ALU_PASS;
    ctrl.fetch_pc_enable = 1'b1;
    state_next = state;
    rti_next = rti_q;
    case (state)
      decode_pkg::IDLE: begin
        if (interrupt) begin
          ctrl.stack = 1'b1;
          ctrl.mem_write = 1'b1;
          ctrl.mem_data_sel = decode_pkg::MEM_PC_LO;
          ctrl.fetch_pc_enable = 1'b0;
          state_next = decode_pkg::INT_PUSH_PC2;
        end else begin
          case (opcode)
            decode_pkg::SETC, decode_pkg::CLRC: begin
              ctrl.alu_op = opcode;  // flag only
            end
            decode_pkg::NOT, decode_pkg::INC, decode_pkg::DEC, decode_pkg::MOV,
            decode_pkg::ADD, decode_pkg::SUB, decode_pkg::AND, decode_pkg::OR,
            decode_pkg::SHL, decode_pkg::SHR: begin
              ctrl.alu_op = opcode;
              ctrl.reg_write = 1'b1;
            end
            decode_pkg::IN: begin
              ctrl.reg_write = 1'b1;
            end
            decode_pkg::PUSH: begin
              ctrl.stack = 1'b1;
              ctrl.mem_write = 1'b1;
            end
            decode_pkg::POP: begin
              ctrl.stack = 1'b1;
              ctrl.mem_read = 1'b1;
              ctrl.mem_to_reg = 1'b1;
              ctrl.reg_write = 1'b1;
            end
            decode_pkg::LDM: begin
              ctrl.fetch_pc_enable = 1'b0;
              state_next = decode_pkg::LDM_IMM;
            end
            decode_pkg::LDD: begin
              ctrl.mem_read = 1'b1;
              ctrl.mem_to_reg = 1'b1;
              ctrl.reg_write = 1'b1;
            end
            decode_pkg::STD: begin
              ctrl.mem_write = 1'b1;
            end
            decode_pkg::JZ, decode_pkg::JN, decode_pkg::JC, decode_pkg::JMP: begin
              ctrl.branch = 1'b1;
              if (taken) ctrl.pc_sel = decode_pkg::PC_JUMP;
            end
            decode_pkg::CALL: begin
              ctrl.branch = 1'b1;
              ctrl.stack = 1'b1;
              ctrl.mem_write = 1'b1;
              ctrl.mem_data_sel = decode_pkg::MEM_PC_LO;  // return address
              if (taken) ctrl.pc_sel = decode_pkg::PC_JUMP;
            end
            decode_pkg::RET, decode_pkg::RTI: begin
              ctrl.stack = 1'b1;
              ctrl.mem_read = 1'b1;
              ctrl.pop_pc1 = 1'b1;
              ctrl.fetch_pc_enable = 1'b0;
              rti_next = (opcode == decode_pkg::RTI);
              state_next = decode_pkg::POP_PC2;
            end
            default: begin
            end
          endcase
        end
      end
      decode_pkg::LDM_IMM: begin
        ctrl.ldm = 1'b1;  // current word is the immediate
        ctrl.alu_src = 1'b1;
        ctrl.reg_write = 1'b1;
        state_next = decode_pkg::IDLE;
      end
      decode_pkg::POP_PC2: begin
        ctrl.stack = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.pop_pc2 = 1'b1;
        if (rti_q) begin
          ctrl.fetch_pc_enable = 1'b0;
          state_next = decode_pkg::POP_CCR;
        end else begin
          ctrl.pc_sel = decode_pkg::PC_POP;
          state_next = decode_pkg::IDLE;
        end
      end
      decode_pkg::POP_CCR: begin
        ctrl.stack = 1'b1;
        ctrl.mem_read = 1'b1;
        ctrl.pop_ccr = 1'b1;
        ctrl.pc_sel = decode_pkg::PC_POP;
        state_next = decode_pkg::IDLE;
      end
      decode_pkg::INT_PUSH_PC2: begin
        ctrl.stack = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.mem_data_sel = decode_pkg::MEM_PC_HI;
        ctrl.fetch_pc_enable = 1'b0;
        state_next = decode_pkg::INT_PUSH_CCR;
      end
      decode_pkg::INT_PUSH_CCR: begin
        ctrl.stack = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.mem_data_sel = decode_pkg::MEM_FLAGS;
        ctrl.pc_sel = decode_pkg::PC_INT;  // vector
        state_next = decode_pkg::IDLE;
      end
      default: begin
        state_next = decode_pkg::IDLE;
      end
    endcase

    // bubble, instruction stays in decode
    if (load_use) begin
      ctrl = '0;
      ctrl.alu_op = decode_pkg::ALU_PASS;
      ctrl.fetch_pc_enable = 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/decode_pkg.sv */
`default_nettype none

package decode_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_addr_t;
  typedef logic [4:0]  opcode_t;
  typedef logic [2:0]  flags_t;
  typedef logic [31:0] pc_t;
  typedef logic [4:0]  alu_op_t;
  typedef logic [1:0]  pc_sel_t;
  typedef logic [1:0]  mem_data_sel_t;

  // flag bit positions
  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_C = 2;

  localparam opcode_t NOP  = 5'b00000;
  localparam opcode_t SETC = 5'b00001;
  localparam opcode_t CLRC = 5'b00010;
  localparam opcode_t NOT  = 5'b00011;
  localparam opcode_t INC  = 5'b00100;
  localparam opcode_t DEC  = 5'b00101;
  localparam opcode_t OUT  = 5'b00110;
  localparam opcode_t IN   = 5'b00111;
  localparam opcode_t MOV  = 5'b01000;
  localparam opcode_t ADD  = 5'b01001;
  localparam opcode_t SUB  = 5'b01010;
  localparam opcode_t AND  = 5'b01011;
  localparam opcode_t OR   = 5'b01100;
  localparam opcode_t SHL  = 5'b01101;
  localparam opcode_t SHR  = 5'b01110;
  localparam opcode_t PUSH = 5'b10000;
  localparam opcode_t POP  = 5'b10001;
  localparam opcode_t LDM  = 5'b10010;
  localparam opcode_t LDD  = 5'b10011;
  localparam opcode_t STD  = 5'b10100;
  localparam opcode_t JZ   = 5'b11000;
  localparam opcode_t JN   = 5'b11001;
  localparam opcode_t JC   = 5'b11010;
  localparam opcode_t JMP  = 5'b11011;
  localparam opcode_t RET  = 5'b11100;
  localparam opcode_t RTI  = 5'b11101;
  localparam opcode_t CALL = 5'b11111;  // low bits 11, always taken

  localparam alu_op_t ALU_PASS = 5'b01111;  // unused opcode slot

  localparam pc_sel_t PC_SEQ  = 2'd0;
  localparam pc_sel_t PC_JUMP = 2'd1;
  localparam pc_sel_t PC_POP  = 2'd2;
  localparam pc_sel_t PC_INT  = 2'd3;

  localparam mem_data_sel_t MEM_REG   = 2'd0;
  localparam mem_data_sel_t MEM_PC_LO = 2'd1;
  localparam mem_data_sel_t MEM_PC_HI = 2'd2;
  localparam mem_data_sel_t MEM_FLAGS = 2'd3;

  typedef struct packed {
    alu_op_t       alu_op;
    logic          alu_src;
    logic          reg_write;
    logic          mem_read;
    logic          mem_write;
    logic          ldm;
    logic          mem_to_reg;
    logic          stack;
    pc_sel_t       pc_sel;
    logic          pop_pc1;
    logic          pop_pc2;
    logic          pop_ccr;
    mem_data_sel_t mem_data_sel;
    logic          fetch_pc_enable;
    logic          branch;
  } ctrl_t;

  localparam ctrl_t CTRL_RESET = '{
    alu_op: '0, alu_src: 1'b0, reg_write: 1'b0, mem_read: 1'b0, mem_write: 1'b0,
    ldm: 1'b0, mem_to_reg: 1'b0, stack: 1'b0, pc_sel: PC_SEQ, pop_pc1: 1'b0,
    pop_pc2: 1'b0, pop_ccr: 1'b0, mem_data_sel: MEM_REG, fetch_pc_enable: 1'b1,
    branch: 1'b0
  };

  typedef enum logic [2:0] {
    IDLE,
    LDM_IMM,
    POP_PC2,
    POP_CCR,
    INT_PUSH_PC2,
    INT_PUSH_CCR
  } seq_state_e;

endpackage

`default_nettype wire

/* hw/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_stage #(
  parameter int width = 16
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  enable,
  input  wire decode_pkg::word_t     instruction,
  input  wire logic                  wb_en,
  input  wire decode_pkg::reg_addr_t wb_addr,
  input  wire logic [width-1:0]      wb_data,
  input  wire decode_pkg::flags_t    flags,
  input  wire logic                  interrupt,
  input  wire logic                  load_use,
  output logic [width-1:0]           op1,
  output logic [width-1:0]           op2,
  output decode_pkg::word_t          imm,
  output decode_pkg::reg_addr_t      rd_addr,
  output decode_pkg::ctrl_t          ctrl,
  output decode_pkg::pc_t            pc_jmp,
  output logic                       flush
);

  decode_pkg::opcode_t   opcode;
  decode_pkg::reg_addr_t rs_addr;
  decode_pkg::reg_addr_t rt_addr;
  decode_pkg::ctrl_t     ctrl_d;
  logic taken;
  logic jump_flush;

  assign opcode  = instruction[15:11];
  assign rs_addr = instruction[10:8];
  assign rt_addr = instruction[7:5];  // second source or destination

  reg_file #(.width(width)) u_reg_file (
    .clk          (clk),
    .rst          (rst),
    .read_enable  (enable),
    .read_addr1   (rs_addr),
    .read_addr2   (rt_addr),
    .read_data1   (op1),
    .read_data2   (op2),
    .write_enable (wb_en),
    .write_addr   (wb_addr),
    .write_data   (wb_data)
  );

  control_unit u_control_unit (
    .clk       (clk),
    .rst       (rst),
    .enable    (enable),
    .opcode    (opcode),
    .interrupt (interrupt),
    .load_use  (load_use),
    .taken     (taken),
    .ctrl      (ctrl_d)
  );

  jump_unit #(.width(width)) u_jump_unit (
    .clk    (clk),
    .rst    (rst),
    .enable (enable),
    .branch (ctrl_d.branch),
    .jtype  (opcode[1:0]),
    .flags  (flags),
    .rdst   (op2),
    .target (pc_jmp),
    .taken  (taken),
    .flush  (jump_flush)
  );

  // id/ex boundary, operands live in the register file read ports
  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl    <= decode_pkg::CTRL_RESET;
      rd_addr <= '0;
      imm     <= '0;
    end else if (enable) begin
      ctrl <= ctrl_d;
      imm  <= instruction;
      if (!ctrl_d.ldm) rd_addr <= rt_addr;  // keep ldm destination
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flush <= 1'b0;
    end else begin
      flush <= jump_flush;  // one cycle behind the jump output
    end
  end

endmodule

`default_nettype wire

/* hw/jump_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module jump_unit #(
  parameter int width = 16
) (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               enable,
  input  wire logic               branch,
  input  wire logic [1:0]         jtype,
  input  wire decode_pkg::flags_t flags,
  input  wire logic [width-1:0]   rdst,
  output decode_pkg::pc_t         target,
  output logic                    taken,
  output logic                    flush
);

  logic cond;

  always_comb begin
    case (jtype)
      2'b00:   cond = flags[decode_pkg::FLAG_Z];
      2'b01:   cond = flags[decode_pkg::FLAG_N];
      2'b10:   cond = flags[decode_pkg::FLAG_C];
      default: cond = 1'b1;  // jmp
    endcase
  end

  assign taken = branch && cond;

  // operand is already the registered read, so target lines up with the output cycle
  assign target = decode_pkg::pc_t'(rdst);

  // high while the taken jump sits in the output register
  // a jump decoded in that cycle is on the wrong path and raises no second flush
  always_ff @(posedge clk) begin
    if (rst) begin
      flush <= 1'b0;
    end else begin
      flush <= enable && taken && !flush;
    end
  end

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file #(
  parameter int width = 16
) (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  read_enable,
  input  wire decode_pkg::reg_addr_t read_addr1,
  input  wire decode_pkg::reg_addr_t read_addr2,
  output logic [width-1:0]           read_data1,
  output logic [width-1:0]           read_data2,
  input  wire logic                  write_enable,
  input  wire decode_pkg::reg_addr_t write_addr,
  input  wire logic [width-1:0]      write_data
);

  logic [width-1:0] regs [8];
  logic hit1;
  logic hit2;

  // same-cycle write seen by the read port
  assign hit1 = write_enable && (write_addr == read_addr1);
  assign hit2 = write_enable && (write_addr == read_addr2);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (write_enable) begin
      regs[write_addr] <= write_data;  // independent of stall
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      read_data1 <= '0;
      read_data2 <= '0;
    end else if (read_enable) begin
      read_data1 <= hit1 ? write_data : regs[read_addr1];
      read_data2 <= hit2 ? write_data : regs[read_addr2];
    end
  end

endmodule

`default_nettype wire

/* verif/decode_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_properties (
  input wire logic              clk,
  input wire logic              rst,
  input wire logic              enable,
  input wire logic              load_use,
  input wire decode_pkg::ctrl_t ctrl,
  input wire logic              flush
);

  single_cycle_flush: assert property (@(posedge clk) disable iff (rst)
    flush |=> !flush)
    else $error("flush stayed high for two cycles");

  stall_holds_ctrl: assert property (@(posedge clk) disable iff (rst)
    !enable |=> $stable(ctrl))
    else $error("ctrl changed while enable was low");

  bubble_stops_fetch: assert property (@(posedge clk) disable iff (rst)
    (enable && load_use) |=> !ctrl.fetch_pc_enable)
    else $error("load_use bubble left fetch_pc_enable high");

  no_read_and_write: assert property (@(posedge clk) disable iff (rst)
    !(ctrl.mem_read && ctrl.mem_write))
    else $error("mem_read and mem_write both high");

endmodule

bind decode_stage decode_properties u_properties (
  .clk      (clk),
  .rst      (rst),
  .enable   (enable),
  .load_use (load_use),
  .ctrl     (ctrl),
  .flush    (flush)
);

`default_nettype wire

/* verif/decode_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_tb;

  localparam int max_tests = 64;

  logic clk;
  logic rst;
  logic enable;
  decode_pkg::word_t instruction;
  logic wb_en;
  decode_pkg::reg_addr_t wb_addr;
  decode_pkg::word_t wb_data;
  decode_pkg::flags_t flags;
  logic interrupt;
  logic load_use;
  decode_pkg::word_t op1;
  decode_pkg::word_t op2;
  decode_pkg::word_t imm;
  decode_pkg::reg_addr_t rd_addr;
  decode_pkg::ctrl_t ctrl;
  decode_pkg::pc_t pc_jmp;
  logic flush;

  string t_name [max_tests];
  logic t_en [max_tests];
  logic t_wbe [max_tests];
  logic [2:0] t_wba [max_tests];
  logic [15:0] t_wbd [max_tests];
  logic [15:0] t_instr [max_tests];
  logic [2:0] t_flags [max_tests];
  logic t_irq [max_tests];
  logic t_lu [max_tests];
  logic [20:0] t_ctrl [max_tests];
  logic [15:0] t_op1 [max_tests];
  logic [15:0] t_op2 [max_tests];
  logic [2:0] t_rd [max_tests];
  logic [31:0] t_pcj [max_tests];
  logic t_flush [max_tests];
  int n_tests;

  decode_pkg::word_t model [8];  // register file contents
  decode_pkg::word_t m_op1;
  decode_pkg::word_t m_op2;
  logic [31:0] rnd;

  tb_clock #(.period(40)) u_clock (.clk(clk), .rst(rst));

  decode_stage #(.width(16)) UUT (
    .clk (clk), .rst (rst), .enable (enable), .instruction (instruction),
    .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data), .flags (flags),
    .interrupt (interrupt), .load_use (load_use), .op1 (op1), .op2 (op2),
    .imm (imm), .rd_addr (rd_addr), .ctrl (ctrl), .pc_jmp (pc_jmp), .flush (flush)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_failure();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (expected === actual)
      else begin
        $display("error %s %s expected %h actual %h", test, what, expected, actual);
        report_failure();
      end
  endtask

  task automatic load_tests();
    int fd;
    int cnt;
    string line;
    fd = $fopen("verif/decode_tests.txt", "r");
    n_tests = 0;
    assert (fd != 0)
      else begin
        $display("the tests file could not be opened");
        report_failure();
      end
    while (!$feof(fd)) begin
      line = "";
      cnt = $fgets(line, fd);
      if (cnt > 3 && line[0] != "#") begin
        cnt = $sscanf(line, "%s %b %b %h %h %h %b %b %b %h %h %h %h %h %b",
          t_name[n_tests], t_en[n_tests], t_wbe[n_tests], t_wba[n_tests],
          t_wbd[n_tests], t_instr[n_tests], t_flags[n_tests], t_irq[n_tests],
          t_lu[n_tests], t_ctrl[n_tests], t_op1[n_tests], t_op2[n_tests],
          t_rd[n_tests], t_pcj[n_tests], t_flush[n_tests]);
        assert (cnt == 15)
          else begin
            $display("a line of the tests file has the wrong number of fields");
            report_failure();
          end
        n_tests++;
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_idle();
    enable <= 1'b1;
    instruction <= '0;
    wb_en <= 1'b0;
    wb_addr <= '0;
    wb_data <= '0;
    flags <= '0;
    interrupt <= 1'b0;
    load_use <= 1'b0;
  endtask

  // also checks the file operands against the register model
  task automatic drive_test(input int i);
    enable <= t_en[i];
    instruction <= t_instr[i];
    wb_en <= t_wbe[i];
    wb_addr <= t_wba[i];
    wb_data <= t_wbd[i];
    flags <= t_flags[i];
    interrupt <= t_irq[i];
    load_use <= t_lu[i];
    if (t_wbe[i]) model[t_wba[i]] = t_wbd[i];  // write lands even in a stall
    if (t_en[i]) begin
      m_op1 = model[t_instr[i][10:8]];
      m_op2 = model[t_instr[i][7:5]];
    end
    check_value({t_name[i], " file"}, "op1", m_op1, t_op1[i]);
    check_value({t_name[i], " file"}, "op2", m_op2, t_op2[i]);
    check_value({t_name[i], " file"}, "pc_jmp", {16'h0, m_op2}, t_pcj[i]);
  endtask

  task automatic check_test(input int i);
    check_value(t_name[i], "ctrl", t_ctrl[i], ctrl);
    check_value(t_name[i], "op1", t_op1[i], op1);
    check_value(t_name[i], "op2", t_op2[i], op2);
    check_value(t_name[i], "rd_addr", t_rd[i], rd_addr);
    check_value(t_name[i], "pc_jmp", t_pcj[i], pc_jmp);
    check_value(t_name[i], "flush", t_flush[i], flush);
    if (t_ctrl[i][11]) check_value(t_name[i], "imm", t_instr[i], imm);  // ldm bit
  endtask

  initial begin
    for (int c = 0; c < 3000; c++) @(posedge clk);
    $display("timeout, the run did not reach its end");
    report_failure();
  end

  initial begin
    int wait_cnt;
    int r;
    logic [1:0] jtype;
    logic [2:0] fl;
    logic exp_taken;
    enable = 1'b0;
    instruction = '0;
    wb_en = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    flags = '0;
    interrupt = 1'b0;
    load_use = 1'b0;
    rnd = 32'h4205_f242;
    m_op1 = '0;
    m_op2 = '0;
    for (int k = 0; k < 8; k++) model[k] = '0;
    load_tests();
    wait_cnt = 0;
    while (rst !== 1'b0 && wait_cnt < 20) begin
      @(negedge clk);
      wait_cnt++;
    end
    assert (rst === 1'b0)
      else begin
        $display("reset was never released");
        report_failure();
      end
    @(negedge clk);
    check_value("reset", "ctrl", 32'h000002, ctrl);
    check_value("reset", "op1", 32'h0, op1);
    check_value("reset", "op2", 32'h0, op2);
    check_value("reset", "flush", 32'h0, flush);

    // test i is driven while test i-1 is checked
    for (int i = 0; i <= n_tests; i++) begin
      @(posedge clk);
      if (i < n_tests) drive_test(i);
      else drive_idle();
      @(negedge clk);
      if (i > 0) check_test(i - 1);
    end

    for (r = 0; r < 8; r++) begin
      rnd = xorshift32(rnd);
      @(posedge clk);
      drive_idle();
      instruction <= {5'b0, 3'(r), 3'(r), 5'b0};
      wb_en <= 1'b1;
      wb_addr <= 3'(r);
      wb_data <= rnd[15:0];
      model[r] = rnd[15:0];
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_value("fill", "op1", model[r], op1);
      check_value("fill", "op2", model[r], op2);
    end

    for (r = 0; r < 8; r++) begin
      @(posedge clk);
      drive_idle();
      instruction <= {5'b0, 3'(r), 3'((r + 1) % 8), 5'b0};
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_value("readback", "op1", model[r], op1);
      check_value("readback", "op2", model[(r + 1) % 8], op2);
      check_value("readback", "rd_addr", (r + 1) % 8, rd_addr);
    end

    // every jump type against every flag pattern
    for (r = 0; r < 32; r++) begin
      jtype = r[4:3];
      fl = r[2:0];
      exp_taken = (jtype == 2'b11) || fl[jtype];
      @(posedge clk);
      drive_idle();
      instruction <= {3'b110, jtype, 3'b000, 3'b001, 5'b0};
      flags <= fl;
      @(posedge clk);
      drive_idle();
      @(negedge clk);
      check_value("jump_sweep", "branch", 32'h1, ctrl.branch);
      check_value("jump_sweep", "pc_sel", exp_taken ? decode_pkg::PC_JUMP : decode_pkg::PC_SEQ,
                  ctrl.pc_sel);
      @(negedge clk);
      check_value("jump_sweep", "flush", exp_taken, flush);
    end

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/decode_tests.txt */
# name en wb_en wb_addr wb_data instr flags(cnz) irq load_use ctrl op1 op2 rd pc_jmp flush
# flush is the value seen in the output cycle of this line
wb_r1 1 1 1 1234 0000 000 0 0 0f0002 0000 0000 0 00000000 0
bypass_r2 1 1 2 00a5 0140 000 0 0 0f0002 1234 00a5 2 000000a5 0
wb_r3 1 1 3 8001 0000 000 0 0 0f0002 0000 0000 0 00000000 0
wb_r4 1 1 4 0040 0000 000 0 0 0f0002 0000 0000 0 00000000 0
add 1 0 0 0000 4940 000 0 0 094002 1234 00a5 2 000000a5 0
not 1 0 0 0000 1b60 000 0 0 034002 8001 8001 3 00008001 0
setc 1 0 0 0000 0800 000 0 0 010002 0000 0000 0 00000000 0
in 1 0 0 0000 3880 000 0 0 0f4002 0000 0040 4 00000040 0
push 1 0 0 0000 8120 000 0 0 0f1202 1234 1234 1 00001234 0
pop 1 0 0 0000 88a0 000 0 0 0f6602 0000 0000 5 00000000 0
ldd 1 0 0 0000 9ac0 000 0 0 0f6402 00a5 0000 6 00000000 0
std 1 0 0 0000 a140 000 0 0 0f1002 1234 00a5 2 000000a5 0
jz_not 1 0 0 0000 c060 000 0 0 0f0003 0000 8001 3 00008001 0
jz_taken 1 0 0 0000 c060 001 0 0 0f0083 0000 8001 3 00008001 0
nop_after_jz 1 0 0 0000 0000 000 0 0 0f0002 0000 0000 0 00000000 1
jn_taken 1 0 0 0000 c880 010 0 0 0f0083 0000 0040 4 00000040 0
nop_after_jn 1 0 0 0000 0000 000 0 0 0f0002 0000 0000 0 00000000 1
jc_not 1 0 0 0000 d080 011 0 0 0f0003 0000 0040 4 00000040 0
jmp 1 0 0 0000 d840 000 0 0 0f0083 0000 00a5 2 000000a5 0
nop_after_jmp 1 0 0 0000 0000 000 0 0 0f0002 0000 0000 0 00000000 1
ldm 1 0 0 0000 90a0 000 0 0 0f0000 0000 0000 5 00000000 0
ldm_imm 1 0 0 0000 5a3c 000 0 0 0fc802 00a5 1234 5 00001234 0
ret 1 0 0 0000 e000 000 0 0 0f2240 0000 0000 0 00000000 0
ret_pc2 1 0 0 0000 0000 000 0 0 0f2322 0000 0000 0 00000000 0
rti 1 0 0 0000 e800 000 0 0 0f2240 0000 0000 0 00000000 0
rti_pc2 1 0 0 0000 0000 000 0 0 0f2220 0000 0000 0 00000000 0
rti_ccr 1 0 0 0000 0000 000 0 0 0f2312 0000 0000 0 00000000 0
int_pc_lo 1 0 0 0000 4940 000 1 0 0f1204 1234 00a5 2 000000a5 0
int_pc_hi 1 0 0 0000 4940 000 0 0 0f1208 1234 00a5 2 000000a5 0
int_ccr 1 0 0 0000 4940 000 0 0 0f138e 1234 00a5 2 000000a5 0
load_use 1 0 0 0000 4940 000 0 1 0f0000 1234 00a5 2 000000a5 0
add_retry 1 0 0 0000 4940 000 0 0 094002 1234 00a5 2 000000a5 0
stall 0 0 0 0000 1b60 000 0 0 094002 1234 00a5 2 000000a5 0
not_after_stall 1 0 0 0000 1b60 000 0 0 034002 8001 8001 3 00008001 0

/* verif/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
  parameter int period = 40
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;  // released after two edges
  end

endmodule

`default_nettype wire
